// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_bus_subsystem
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "=== PASS ===" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
verilog/spu_bus_pkg.sv
verilog/mem_issue.sv
verilog/cpu_bus.sv
verilog/byte_ram.sv
verilog/load_writeback.sv
verilog/bus_subsystem_top.sv
tests/tb_bus_subsystem.sv

// ==== tests/tb_bus_subsystem.sv ====
`timescale 1ns/1ps

module tb_bus_subsystem;

    localparam int WAIT_CYCLES = 2;
    localparam int ADDR_BITS   = 8;
    localparam int REG_COUNT   = 8;
    localparam int RD_BITS     = $clog2(REG_COUNT);
    localparam int RAM_BYTES   = 2 ** ADDR_BITS;
    localparam int RAM_WORDS   = RAM_BYTES / 4;
    localparam int NUM_REQ     = 400;
    localparam int CYCLE_LIMIT = 40 * (NUM_REQ + RAM_WORDS);
    // first strobe cycle, the wait cycles, one accept cycle, then done
    localparam int DONE_LAT    = WAIT_CYCLES + 2;

    logic                I_clk;
    logic                rst_n;
    logic                req_valid;
    spu_bus_pkg::busop_t req_op;
    logic [ADDR_BITS-1:0] req_addr;
    logic [31:0]         req_data;
    logic [RD_BITS-1:0]  req_rd;
    logic                req_ready;
    logic                done;
    logic [RD_BITS-1:0]  rd_sel;
    logic [31:0]         rd_data;

    // little-endian byte image of the RAM and the load registers
    logic [7:0]  mem_model [RAM_BYTES];
    logic [31:0] reg_model [REG_COUNT];

    logic [31:0] rng_state = 32'h643f;
    int          checks;
    int          value_errors;
    int          timing_errors;
    int          cycle_count;

    bus_subsystem_top #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .ADDR_BITS   (ADDR_BITS),
        .REG_COUNT   (REG_COUNT)
    ) u_dut (
        .I_clk     (I_clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .req_rd    (req_rd),
        .req_ready (req_ready),
        .done      (done),
        .rd_sel    (rd_sel),
        .rd_data   (rd_data)
    );

    initial begin
        I_clk = 1'b0;
        forever #4 I_clk = ~I_clk;
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // expected register value of a load, taken from the byte image
    function automatic logic [31:0] load_value(input spu_bus_pkg::busop_t op_in, input int a);
        logic [7:0]  b;
        logic [15:0] h;
        b = mem_model[a];
        h = {mem_model[a+1], mem_model[a]};
        case (op_in)
            spu_bus_pkg::READB:  return {{24{b[7]}}, b};
            spu_bus_pkg::READBU: return {24'd0, b};
            spu_bus_pkg::READH:  return {{16{h[15]}}, h};
            spu_bus_pkg::READHU: return {16'd0, h};
            default:             return {mem_model[a+3], mem_model[a+2], h};
        endcase
    endfunction

    task automatic run_request(input spu_bus_pkg::busop_t op_in, input int addr_in,
                               input logic [31:0] data_in, input int rd_in);
        int lat;
        int nbytes;
        @(negedge I_clk);
        while (!req_ready) begin
            @(negedge I_clk);
        end
        @(posedge I_clk);
        req_valid <= 1'b1;
        req_op    <= op_in;
        req_addr  <= ADDR_BITS'(addr_in);
        req_data  <= data_in;
        req_rd    <= RD_BITS'(rd_in);
        // request is taken on this edge
        @(posedge I_clk);
        req_valid <= 1'b0;
        lat = 0;
        @(negedge I_clk);
        while (!done) begin
            checks++;
            assert (!req_ready) else begin
                timing_errors++;
                $display("FAIL %0t: req_ready high while %s is in flight", $time, op_in.name());
            end
            lat++;
            @(negedge I_clk);
        end
        checks++;
        assert (!req_ready && lat == DONE_LAT) else begin
            timing_errors++;
            $display("FAIL %0t: %s done after %0d cycles with req_ready %0b, expected %0d",
                     $time, op_in.name(), lat, req_ready, DONE_LAT);
        end
        if (op_in inside {spu_bus_pkg::WRITEB, spu_bus_pkg::WRITEH, spu_bus_pkg::WRITEW}) begin
            nbytes = (op_in == spu_bus_pkg::WRITEW) ? 4 : (op_in == spu_bus_pkg::WRITEH) ? 2 : 1;
            for (int i = 0; i < nbytes; i++) begin
                mem_model[addr_in+i] = data_in[8*i +: 8];
            end
        end else begin
            reg_model[rd_in] = load_value(op_in, addr_in);
        end
        @(negedge I_clk);
        checks++;
        assert (req_ready && !done) else begin
            timing_errors++;
            $display("FAIL %0t: issuer not idle in the cycle after done of %s",
                     $time, op_in.name());
        end
        // every register, so a stray write shows up too
        for (int i = 0; i < REG_COUNT; i++) begin
            @(posedge I_clk);
            rd_sel <= RD_BITS'(i);
            @(negedge I_clk);
            checks++;
            assert (rd_data === reg_model[i]) else begin
                value_errors++;
                $display("FAIL %0t: after %s at 0x%0h reg %0d is %08h, expected %08h",
                         $time, op_in.name(), addr_in, i, rd_data, reg_model[i]);
            end
        end
    endtask

    initial begin
        logic [31:0]         r;
        spu_bus_pkg::busop_t op_v;
        int                  a;
        rst_n         = 1'b0;
        req_valid     = 1'b0;
        req_op        = spu_bus_pkg::READW;
        req_addr      = '0;
        req_data      = '0;
        req_rd        = '0;
        rd_sel        = '0;
        checks        = 0;
        value_errors  = 0;
        timing_errors = 0;
        for (int i = 0; i < REG_COUNT; i++) begin
            reg_model[i] = '0;
        end
        repeat (16) @(posedge I_clk);
        rst_n <= 1'b1;
        @(negedge I_clk);
        checks++;
        assert (req_ready && !done) else begin
            timing_errors++;
            $display("FAIL %0t: after reset req_ready=%0b done=%0b", $time, req_ready, done);
        end

        // fill the RAM so the byte image is fully defined
        for (int w = 0; w < RAM_WORDS; w++) begin
            run_request(spu_bus_pkg::WRITEW, 4 * w, next_rand(), 0);
        end

        for (int n = 0; n < NUM_REQ; n++) begin
            r    = next_rand();
            op_v = spu_bus_pkg::busop_t'(r[31:29]);
            a    = int'((r >> 8) % RAM_BYTES);
            if (op_v inside {spu_bus_pkg::READH, spu_bus_pkg::READHU, spu_bus_pkg::WRITEH}) begin
                a = a - (a % 2);
            end else if (op_v inside {spu_bus_pkg::READW, spu_bus_pkg::WRITEW}) begin
                a = a - (a % 4);
            end
            run_request(op_v, a, next_rand(), int'((r >> 24) % REG_COUNT));
        end

        $display("checks: %0d, value errors: %0d, timing errors: %0d",
                 checks, value_errors, timing_errors);
        if (value_errors + timing_errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    // hang guard
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge I_clk);
            cycle_count++;
        end
        $display("timeout: the test did not finish within %0d clock cycles", CYCLE_LIMIT);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== verilog/bus_subsystem_top.sv ====
`timescale 1ns/1ps

module bus_subsystem_top #(
    parameter int WAIT_CYCLES = 2,
    parameter int ADDR_BITS   = 8,
    parameter int REG_COUNT   = 8
) (
    input  logic                         I_clk,
    input  logic                         rst_n,
    input  logic                         req_valid,
    input  spu_bus_pkg::busop_t          req_op,
    input  logic [ADDR_BITS-1:0]         req_addr,
    input  logic [31:0]                  req_data,
    input  logic [$clog2(REG_COUNT)-1:0] req_rd,
    output logic                         req_ready,
    output logic                         done,
    input  logic [$clog2(REG_COUNT)-1:0] rd_sel,
    output logic [31:0]                  rd_data
);

    localparam int RD_BITS = $clog2(REG_COUNT);

    // issuer to adapter
    logic                en;
    spu_bus_pkg::busop_t op;
    logic [31:0]         addr;
    logic [31:0]         data;
    logic                busy;
    logic [31:0]         rdata;

    // adapter to RAM
    logic                bus_strobe;
    logic [31:0]         bus_addr;
    logic [31:0]         bus_data;
    logic                bus_write;
    logic                bus_halfword;
    logic                bus_fullword;
    logic [31:0]         bus_rdata;
    logic                bus_wait;

    // issuer to writeback
    logic                wb_en;
    logic [RD_BITS-1:0]  wb_rd;

    mem_issue #(
        .ADDR_BITS (ADDR_BITS),
        .REG_COUNT (REG_COUNT)
    ) u_issue (
        .I_clk     (I_clk),
        .rst_n     (rst_n),
        .req_valid (req_valid),
        .req_op    (req_op),
        .req_addr  (req_addr),
        .req_data  (req_data),
        .req_rd    (req_rd),
        .busy      (busy),
        .req_ready (req_ready),
        .done      (done),
        .en        (en),
        .op        (op),
        .addr      (addr),
        .data      (data),
        .wb_en     (wb_en),
        .wb_rd     (wb_rd)
    );

    cpu_bus u_bus (
        .I_clk        (I_clk),
        .rst_n        (rst_n),
        .en           (en),
        .op           (op),
        .addr         (addr),
        .data         (data),
        .bus_rdata    (bus_rdata),
        .bus_wait     (bus_wait),
        .rdata        (rdata),
        .busy         (busy),
        .bus_strobe   (bus_strobe),
        .bus_addr     (bus_addr),
        .bus_data     (bus_data),
        .bus_write    (bus_write),
        .bus_halfword (bus_halfword),
        .bus_fullword (bus_fullword)
    );

    // RAM decodes only the low address bits
    byte_ram #(
        .WAIT_CYCLES (WAIT_CYCLES),
        .ADDR_BITS   (ADDR_BITS)
    ) u_ram (
        .I_clk        (I_clk),
        .rst_n        (rst_n),
        .bus_strobe   (bus_strobe),
        .bus_addr     (bus_addr[ADDR_BITS-1:0]),
        .bus_data     (bus_data),
        .bus_write    (bus_write),
        .bus_halfword (bus_halfword),
        .bus_fullword (bus_fullword),
        .bus_rdata    (bus_rdata),
        .bus_wait     (bus_wait)
    );

    load_writeback #(
        .REG_COUNT (REG_COUNT)
    ) u_wb (
        .I_clk   (I_clk),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .rdata   (rdata),
        .rd_sel  (rd_sel),
        .rd_data (rd_data)
    );

endmodule

// ==== verilog/byte_ram.sv ====
`timescale 1ns/1ps

module byte_ram #(
    parameter int WAIT_CYCLES = 2,
    parameter int ADDR_BITS   = 8
) (
    input  logic                 I_clk,
    input  logic                 rst_n,
    input  logic                 bus_strobe,
    input  logic [ADDR_BITS-1:0] bus_addr,
    input  logic [31:0]          bus_data,
    input  logic                 bus_write,
    input  logic                 bus_halfword,
    input  logic                 bus_fullword,
    output logic [31:0]          bus_rdata,
    output logic                 bus_wait
);

    localparam int WORDS    = 2 ** (ADDR_BITS - 2);
    // wait covers the first strobe cycle plus WAIT_CYCLES more
    localparam int CNT_BITS = $clog2(WAIT_CYCLES + 2);
    localparam logic [CNT_BITS-1:0] WAIT_LAST = CNT_BITS'(WAIT_CYCLES + 1);

    logic [31:0]          mem [WORDS];
    logic [CNT_BITS-1:0]  wait_cnt;
    logic [1:0]           lane;
    logic [ADDR_BITS-3:0] word_idx;
    logic [3:0]           byte_en;
    logic [31:0]          wdata;
    logic                 accept;

    assign lane     = bus_addr[1:0];
    assign word_idx = bus_addr[ADDR_BITS-1:2];
    assign bus_wait = bus_strobe && (wait_cnt != WAIT_LAST);
    assign accept   = bus_strobe && !bus_wait;

    // lanes touched by this access
    always_comb begin
        if (bus_fullword) begin
            byte_en = 4'b1111;
        end else if (bus_halfword) begin
            byte_en = 4'b0011 << lane;
        end else begin
            byte_en = 4'b0001 << lane;
        end
    end

    // store data moved up to its lanes
    assign wdata = bus_data << {lane, 3'b000};

    // counts strobe cycles, restarts after each accepted access
    always_ff @(posedge I_clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (!bus_strobe || accept) begin
            wait_cnt <= '0;
        end else begin
            wait_cnt <= wait_cnt + 1'b1;
        end
    end

    always_ff @(posedge I_clk) begin
        if (accept && bus_write) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem[word_idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // addressed bytes land in the low lanes
    always_ff @(posedge I_clk) begin
        if (accept && !bus_write) begin
            bus_rdata <= mem[word_idx] >> {lane, 3'b000};
        end
    end

    a_half_aligned: assert property (
        @(posedge I_clk) disable iff (!rst_n)
        (bus_strobe && bus_halfword) |-> (bus_addr[0] == 1'b0)
    );

    a_word_aligned: assert property (
        @(posedge I_clk) disable iff (!rst_n)
        (bus_strobe && bus_fullword) |-> (bus_addr[1:0] == 2'b00)
    );

    a_one_width: assert property (
        @(posedge I_clk) disable iff (!rst_n)
        bus_strobe |-> !(bus_halfword && bus_fullword)
    );

endmodule

// ==== verilog/cpu_bus.sv ====
`timescale 1ns/1ps

module cpu_bus (
    input  logic                I_clk,
    input  logic                rst_n,
    input  logic                en,
    input  spu_bus_pkg::busop_t op,
    input  logic [31:0]         addr,
    input  logic [31:0]         data,
    input  logic [31:0]         bus_rdata,
    input  logic                bus_wait,
    output logic [31:0]         rdata,
    output logic                busy,
    output logic                bus_strobe,
    output logic [31:0]         bus_addr,
    output logic [31:0]         bus_data,
    output logic                bus_write,
    output logic                bus_halfword,
    output logic                bus_fullword
);

    spu_bus_pkg::busop_t last_op;

    assign busy       = bus_wait;
    assign bus_strobe = en;
    assign bus_addr   = addr;
    assign bus_data   = data;

    // access width from the opcode, byte is the default
    always_comb begin
        bus_halfword = 1'b0;
        bus_fullword = 1'b0;
        bus_write    = 1'b0;
        case (op)
            spu_bus_pkg::READH, spu_bus_pkg::READHU: bus_halfword = 1'b1;
            spu_bus_pkg::READW:  bus_fullword = 1'b1;
            spu_bus_pkg::WRITEB: bus_write = 1'b1;
            spu_bus_pkg::WRITEH: begin
                bus_write    = 1'b1;
                bus_halfword = 1'b1;
            end
            spu_bus_pkg::WRITEW: begin
                bus_write    = 1'b1;
                bus_fullword = 1'b1;
            end
            default: ;
        endcase
    end

    // keeps the extension right after the issuer has moved on
    always_ff @(posedge I_clk or negedge rst_n) begin
        if (!rst_n) begin
            last_op <= spu_bus_pkg::READW;
        end else if (en) begin
            last_op <= op;
        end
    end

    always_comb begin
        case (last_op)
            spu_bus_pkg::READB:  rdata = {{24{bus_rdata[7]}}, bus_rdata[7:0]};
            spu_bus_pkg::READBU: rdata = {24'd0, bus_rdata[7:0]};
            spu_bus_pkg::READH:  rdata = {{16{bus_rdata[15]}}, bus_rdata[15:0]};
            spu_bus_pkg::READHU: rdata = {16'd0, bus_rdata[15:0]};
            default:             rdata = bus_rdata;
        endcase
    end

endmodule

// ==== verilog/load_writeback.sv ====
`timescale 1ns/1ps

module load_writeback #(
    parameter int REG_COUNT = 8
) (
    input  logic                         I_clk,
    input  logic                         rst_n,
    input  logic                         wb_en,
    input  logic [$clog2(REG_COUNT)-1:0] wb_rd,
    input  logic [31:0]                  rdata,
    input  logic [$clog2(REG_COUNT)-1:0] rd_sel,
    output logic [31:0]                  rd_data
);

    logic [31:0] regs [REG_COUNT];

    // written only by completed loads
    always_ff @(posedge I_clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= rdata;
        end
    end

    // asynchronous read port
    assign rd_data = regs[rd_sel];

endmodule

// ==== verilog/mem_issue.sv ====
`timescale 1ns/1ps

module mem_issue #(
    parameter int ADDR_BITS = 8,
    parameter int REG_COUNT = 8
) (
    input  logic                         I_clk,
    input  logic                         rst_n,
    input  logic                         req_valid,
    input  spu_bus_pkg::busop_t          req_op,
    input  logic [ADDR_BITS-1:0]         req_addr,
    input  logic [31:0]                  req_data,
    input  logic [$clog2(REG_COUNT)-1:0] req_rd,
    input  logic                         busy,
    output logic                         req_ready,
    output logic                         done,
    output logic                         en,
    output spu_bus_pkg::busop_t          op,
    output logic [31:0]                  addr,
    output logic [31:0]                  data,
    output logic                         wb_en,
    output logic [$clog2(REG_COUNT)-1:0] wb_rd
);

    spu_bus_pkg::issue_state_t state;

    // holding registers for the one request in flight
    spu_bus_pkg::busop_t          op_q;
    logic [ADDR_BITS-1:0]         addr_q;
    logic [31:0]                  data_q;
    logic [$clog2(REG_COUNT)-1:0] rd_q;
    logic                         is_load;

    always_ff @(posedge I_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= spu_bus_pkg::IDLE;
        end else begin
            case (state)
                spu_bus_pkg::IDLE: begin
                    if (req_valid) begin
                        state <= spu_bus_pkg::BUS;
                    end
                end
                // stay on the bus until the RAM stops waiting
                spu_bus_pkg::BUS: begin
                    if (!busy) begin
                        state <= spu_bus_pkg::DONE;
                    end
                end
                default: begin
                    state <= spu_bus_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge I_clk) begin
        if (req_valid && req_ready) begin
            op_q   <= req_op;
            addr_q <= req_addr;
            data_q <= req_data;
            rd_q   <= req_rd;
        end
    end

    assign is_load = (op_q == spu_bus_pkg::READB) || (op_q == spu_bus_pkg::READBU) ||
                     (op_q == spu_bus_pkg::READH) || (op_q == spu_bus_pkg::READHU) ||
                     (op_q == spu_bus_pkg::READW);

    assign req_ready = (state == spu_bus_pkg::IDLE);
    assign en        = (state == spu_bus_pkg::BUS);
    assign done      = (state == spu_bus_pkg::DONE);
    assign wb_en     = done && is_load;
    assign op        = op_q;
    assign addr      = {{(32 - ADDR_BITS){1'b0}}, addr_q};
    assign data      = data_q;
    assign wb_rd     = rd_q;

    // the RAM must see a steady request for the whole wait period
    a_hold_while_busy: assert property (
        @(posedge I_clk) disable iff (!rst_n)
        (en && busy) |=> (en && $stable(op) && $stable(addr))
    );

endmodule

// ==== verilog/spu_bus_pkg.sv ====
package spu_bus_pkg;

    // bus operations, loads first
    // encoding follows the core's busop field
    typedef enum logic [2:0] {
        READB  = 3'b000,
        READBU = 3'b001,
        READH  = 3'b010,
        READHU = 3'b011,
        READW  = 3'b100,
        WRITEB = 3'b101,
        WRITEH = 3'b110,
        WRITEW = 3'b111
    } busop_t;

    // request issuer states
    typedef enum logic [1:0] {
        IDLE = 2'b00,
        BUS  = 2'b01,
        DONE = 2'b10
    } issue_state_t;

endpackage
